// File: Bender.yml
package:
  name: umi_mem_agent

sources:
  # Packages first, then the array blocks and the top level
  - files:
      - common/umi_pkg.sv
      - common/mem_agent_pkg.sv
      - mem_array/mem_spram.sv
      - mem_array/mem_access_align.sv
      - source/mem_clear_counter.sv
      - source/umi_endpoint_ctrl.sv
      - source/umi_mem_agent.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/umi_mem_agent_assert.sv
      - verif/umi_mem_agent_tb.sv

// File: common/mem_agent_pkg.sv
`default_nettype none

package mem_agent_pkg;

   // Row width of the array and of the data port
   localparam int DW     = 64;
   localparam int NBYTES = DW / 8;             // Byte lanes per row
   localparam int OFFW   = $clog2(NBYTES);     // Byte offset inside a row

   // Array depth
   localparam int RAMDEPTH = 64;
   localparam int ROWW     = $clog2(RAMDEPTH); // Row index bits

   // Byte count of one transfer, (len + 1) << size
   localparam int BCW = 16;

   typedef logic [DW-1:0] mem_data_t;

endpackage

`default_nettype wire

// File: common/umi_pkg.sv
`default_nettype none

package umi_pkg;

   // ##########################################################
   // Word widths
   // ##########################################################

   localparam int CW = 32;                // Command word
   localparam int AW = 32;                // Source and destination address

   typedef logic [CW-1:0] umi_cmd_t;
   typedef logic [AW-1:0] umi_addr_t;

   // ##########################################################
   // Command field layout
   // ##########################################################

   localparam int OPW   = 5;              // Opcode bits
   localparam int SIZEW = 3;              // Log2 of bytes per word
   localparam int LENW  = 8;              // Words minus one

   localparam int CMD_OPCODE_LSB = 0;     // Bits 4..0
   localparam int CMD_SIZE_LSB   = 5;     // Bits 7..5
   localparam int CMD_LEN_LSB    = 8;     // Bits 15..8

   // ##########################################################
   // Opcodes
   // ##########################################################

   // Requests seen on the device port
   localparam logic [OPW-1:0] OP_REQ_RD       = 5'h01;
   localparam logic [OPW-1:0] OP_REQ_WR       = 5'h03;
   localparam logic [OPW-1:0] OP_REQ_WRPOSTED = 5'h05;

   // Responses sent back
   localparam logic [OPW-1:0] OP_RESP_RD = 5'h02;   // Read data
   localparam logic [OPW-1:0] OP_RESP_WR = 5'h04;   // Write acknowledge

endpackage

`default_nettype wire

// File: filelist.f
common/umi_pkg.sv
common/mem_agent_pkg.sv
mem_array/mem_spram.sv
mem_array/mem_access_align.sv
source/mem_clear_counter.sv
source/umi_endpoint_ctrl.sv
source/umi_mem_agent.sv
verif/umi_mem_agent_assert.sv
verif/umi_mem_agent_tb.sv

// File: mem_array/mem_access_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_align
   import umi_pkg::*;
   import mem_agent_pkg::*;
(
   // Clear sequencer
   input  logic             clear_active,
   input  logic [ROWW-1:0]  clear_row,
   // Controller side
   input  umi_addr_t        loc_addr,
   input  logic [SIZEW-1:0] loc_size,
   input  logic [LENW-1:0]  loc_len,
   input  mem_data_t        loc_wrdata,
   input  logic             loc_write,
   input  logic             loc_read,
   output mem_data_t        loc_rddata,
   // RAM side
   output logic             ram_ce,
   output logic             ram_we,
   output logic [ROWW-1:0]  ram_addr,
   output logic [NBYTES-1:0] ram_wmask,
   output mem_data_t        ram_din,
   input  mem_data_t        ram_dout
);

   logic [OFFW-1:0]   offset;        // First byte inside the row
   logic [BCW-1:0]    nbytes;        // Bytes in the transfer
   logic [BCW:0]      end_byte;      // One past the last byte
   logic [NBYTES-1:0] lane_mask;
   logic [NBYTES-1:0] keep_mask;     // Valid lanes after the down shift
   mem_data_t         wr_shift;
   mem_data_t         rd_shift;

   assign offset   = loc_addr[OFFW-1:0];
   assign nbytes   = (BCW'(loc_len) + 1'b1) << loc_size;
   assign end_byte = {1'b0, nbytes} + offset;

   // ##########################################################
   // Byte lanes
   // ##########################################################

   always_comb begin
      for (int i = 0; i < NBYTES; i++) begin
         lane_mask[i] = (i >= int'(offset)) && (i < int'(end_byte));
         keep_mask[i] = (i < int'(nbytes));
      end
   end

   assign wr_shift = loc_wrdata << {offset, 3'b000};   // Up to the start lane
   assign rd_shift = ram_dout >> {offset, 3'b000};     // Down to byte 0

   // Bytes past the transfer read back as zero
   always_comb begin
      for (int i = 0; i < NBYTES; i++) begin
         loc_rddata[8*i +: 8] = keep_mask[i] ? rd_shift[8*i +: 8] : 8'h00;
      end
   end

   // ##########################################################
   // RAM port select
   // ##########################################################

   // Clear sequence owns the port while active
   assign ram_we    = clear_active || loc_write;
   assign ram_ce    = ram_we || loc_read;
   assign ram_addr  = clear_active ? clear_row : loc_addr[OFFW +: ROWW];
   assign ram_wmask = clear_active ? '1 : lane_mask;
   assign ram_din   = clear_active ? '0 : wr_shift;

endmodule

`default_nettype wire

// File: mem_array/mem_spram.sv
`timescale 1ns/1ps
`default_nettype none

module mem_spram
   import mem_agent_pkg::*;
(
   input  logic              clk,
   input  logic              ce,       // Enables read and write
   input  logic              we,
   input  logic [NBYTES-1:0] wmask,    // One bit per byte lane
   input  logic [ROWW-1:0]   addr,
   input  mem_data_t         din,
   output mem_data_t         dout
);

   // ##########################################################
   // Storage
   // ##########################################################

   mem_data_t mem [RAMDEPTH];

   // Registered read, old data on a write edge
   always_ff @(posedge clk) begin
      if (ce) begin
         dout <= mem[addr];
      end
   end

   // Masked byte writes
   always_ff @(posedge clk) begin
      if (ce && we) begin
         for (int i = 0; i < NBYTES; i++) begin
            if (wmask[i]) begin
               mem[addr][8*i +: 8] <= din[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/mem_clear_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_clear_counter
   import mem_agent_pkg::*;
(
   input  logic            clk,
   input  logic            rst,
   output logic            clear_active,   // High while rows are zeroed
   output logic [ROWW-1:0] clear_row       // Row written this cycle
);

   // ##########################################################
   // Zero-fill sequencer
   // ##########################################################

   // One row per cycle, starting at row 0 out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         clear_active <= 1'b1;
         clear_row    <= '0;
      end else if (clear_active) begin
         clear_row <= clear_row + 1'b1;      // Wraps to zero after last row
         if (clear_row == ROWW'(RAMDEPTH - 1)) begin
            clear_active <= 1'b0;            // Done, idle until next reset
         end
      end
   end

endmodule

`default_nettype wire

// File: source/umi_endpoint_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module umi_endpoint_ctrl
   import umi_pkg::*;
   import mem_agent_pkg::*;
(
   input  logic             clk,
   input  logic             rst,
   input  logic             clear_active,   // Array zero-fill in progress
   // Device port request
   input  logic             req_valid,
   input  umi_cmd_t         req_cmd,
   input  umi_addr_t        req_dstaddr,
   input  umi_addr_t        req_srcaddr,
   input  mem_data_t        req_data,
   output logic             req_ready,
   // Device port response
   output logic             resp_valid,
   output umi_cmd_t         resp_cmd,
   output umi_addr_t        resp_dstaddr,
   output umi_addr_t        resp_srcaddr,
   output mem_data_t        resp_data,
   input  logic             resp_ready,
   // Local access side
   output umi_addr_t        loc_addr,
   output logic [SIZEW-1:0] loc_size,
   output logic [LENW-1:0]  loc_len,
   output mem_data_t        loc_wrdata,
   output logic             loc_write,
   output logic             loc_read,
   input  mem_data_t        loc_rddata      // Already aligned to byte 0
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      RESP
   } state_t;

   state_t         state;
   logic [OPW-1:0] req_op;
   logic           is_rd;                    // Decoded at capture
   logic           is_wr;
   logic           is_posted;
   umi_addr_t      src_addr;                 // Return address for the response
   umi_cmd_t       resp_cmd_nxt;

   assign req_op = req_cmd[CMD_OPCODE_LSB +: OPW];

   // One transaction at a time, and none during clear
   assign req_ready = (state == IDLE) && !clear_active;

   // Access pulses, one cycle in ACCESS
   assign loc_read  = (state == ACCESS) && is_rd;
   assign loc_write = (state == ACCESS) && (is_wr || is_posted);

   // ##########################################################
   // State machine
   // ##########################################################

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         resp_valid <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (req_valid && req_ready) begin
                  state <= ACCESS;
               end
            end
            ACCESS: begin
               // Posted and unknown opcodes finish here
               if (is_rd || is_wr) begin
                  state <= RESP;
               end else begin
                  state <= IDLE;
               end
            end
            RESP: begin
               if (!resp_valid) begin
                  resp_valid <= 1'b1;          // RAM output settled, load response
               end else if (resp_ready) begin
                  resp_valid <= 1'b0;
                  state      <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ##########################################################
   // Request capture
   // ##########################################################

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         loc_addr   <= req_dstaddr;
         src_addr   <= req_srcaddr;
         loc_size   <= req_cmd[CMD_SIZE_LSB +: SIZEW];
         loc_len    <= req_cmd[CMD_LEN_LSB +: LENW];
         loc_wrdata <= req_data;
         is_rd      <= (req_op == OP_REQ_RD);
         is_wr      <= (req_op == OP_REQ_WR);
         is_posted  <= (req_op == OP_REQ_WRPOSTED);
      end
   end

   // Response command keeps size and length of the request
   always_comb begin
      resp_cmd_nxt                              = '0;
      resp_cmd_nxt[CMD_OPCODE_LSB +: OPW]       = is_rd ? OP_RESP_RD : OP_RESP_WR;
      resp_cmd_nxt[CMD_SIZE_LSB +: SIZEW]       = loc_size;
      resp_cmd_nxt[CMD_LEN_LSB +: LENW]         = loc_len;
   end

   // Response registers, held until taken
   always_ff @(posedge clk) begin
      if ((state == RESP) && !resp_valid) begin
         resp_cmd     <= resp_cmd_nxt;
         resp_dstaddr <= src_addr;               // Swapped header
         resp_srcaddr <= loc_addr;
         resp_data    <= is_rd ? loc_rddata : '0; // Ack carries no data
      end
   end

endmodule

`default_nettype wire

// File: source/umi_mem_agent.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent
   import umi_pkg::*;
   import mem_agent_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Device port request
   input  logic      req_valid,
   input  umi_cmd_t  req_cmd,
   input  umi_addr_t req_dstaddr,
   input  umi_addr_t req_srcaddr,
   input  mem_data_t req_data,
   output logic      req_ready,
   // Device port response
   output logic      resp_valid,
   output umi_cmd_t  resp_cmd,
   output umi_addr_t resp_dstaddr,
   output umi_addr_t resp_srcaddr,
   output mem_data_t resp_data,
   input  logic      resp_ready
);

   // Controller to aligner
   umi_addr_t         loc_addr;
   logic [SIZEW-1:0]  loc_size;
   logic [LENW-1:0]   loc_len;
   mem_data_t         loc_wrdata;
   mem_data_t         loc_rddata;
   logic              loc_write;
   logic              loc_read;
   // Clear sequence
   logic              clear_active;
   logic [ROWW-1:0]   clear_row;
   // RAM port
   logic              ram_ce;
   logic              ram_we;
   logic [ROWW-1:0]   ram_addr;
   logic [NBYTES-1:0] ram_wmask;
   mem_data_t         ram_din;
   mem_data_t         ram_dout;

   // ##########################################################
   // Device port endpoint
   // ##########################################################

   umi_endpoint_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .clear_active (clear_active),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .loc_addr     (loc_addr),
      .loc_size     (loc_size),
      .loc_len      (loc_len),
      .loc_wrdata   (loc_wrdata),
      .loc_write    (loc_write),
      .loc_read     (loc_read),
      .loc_rddata   (loc_rddata)
   );

   mem_clear_counter u_clear (
      .clk          (clk),
      .rst          (rst),
      .clear_active (clear_active),
      .clear_row    (clear_row)
   );

   // ##########################################################
   // Array
   // ##########################################################

   mem_access_align u_align (
      .clear_active (clear_active),
      .clear_row    (clear_row),
      .loc_addr     (loc_addr),
      .loc_size     (loc_size),
      .loc_len      (loc_len),
      .loc_wrdata   (loc_wrdata),
      .loc_write    (loc_write),
      .loc_read     (loc_read),
      .loc_rddata   (loc_rddata),
      .ram_ce       (ram_ce),
      .ram_we       (ram_we),
      .ram_addr     (ram_addr),
      .ram_wmask    (ram_wmask),
      .ram_din      (ram_din),
      .ram_dout     (ram_dout)
   );

   mem_spram u_ram (
      .clk   (clk),
      .ce    (ram_ce),
      .we    (ram_we),
      .wmask (ram_wmask),
      .addr  (ram_addr),
      .din   (ram_din),
      .dout  (ram_dout)
   );

endmodule

`default_nettype wire

// File: verif/umi_mem_agent_assert.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent_assert
   import umi_pkg::*;
   import mem_agent_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input logic      req_ready,
   input logic      resp_valid,
   input logic      resp_ready,
   input umi_cmd_t  resp_cmd,
   input umi_addr_t resp_dstaddr,
   input umi_addr_t resp_srcaddr,
   input mem_data_t resp_data
);

   int fail_count = 0;   // Failed assertions so far

   // ##########################################################
   // Device port handshake
   // ##########################################################

   // Stalled response keeps every field
   a_resp_hold: assert property (@(posedge clk) disable iff (rst)
      (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_cmd)
         && $stable(resp_dstaddr) && $stable(resp_srcaddr) && $stable(resp_data)))
      else begin
         $error("response changed while stalled");
         fail_count++;
      end

   // No new request while a response is out
   a_ready_low: assert property (@(posedge clk) disable iff (rst)
      resp_valid |-> !req_ready)
      else begin
         $error("req_ready high while resp_valid high");
         fail_count++;
      end

endmodule

bind umi_mem_agent umi_mem_agent_assert u_assert (
   .clk          (clk),
   .rst          (rst),
   .req_ready    (req_ready),
   .resp_valid   (resp_valid),
   .resp_ready   (resp_ready),
   .resp_cmd     (resp_cmd),
   .resp_dstaddr (resp_dstaddr),
   .resp_srcaddr (resp_srcaddr),
   .resp_data    (resp_data)
);

`default_nettype wire

// File: verif/umi_mem_agent_tb.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_agent_tb
   import umi_pkg::*;
   import mem_agent_pkg::*;
();

   localparam int CYCLE_LIMIT = RAMDEPTH + 600 * 12;   // Clear plus worst-case transactions

   logic      clk;
   logic      rst;
   logic      req_valid;
   umi_cmd_t  req_cmd;
   umi_addr_t req_dstaddr;
   umi_addr_t req_srcaddr;
   mem_data_t req_data;
   logic      req_ready;
   logic      resp_valid;
   umi_cmd_t  resp_cmd;
   umi_addr_t resp_dstaddr;
   umi_addr_t resp_srcaddr;
   mem_data_t resp_data;
   logic      resp_ready;

   int seed;
   int ready_pct;                          // Chance of resp_ready per cycle
   int errors;
   int checks;
   int ntests;
   int npass;
   int test_err0;                          // Error total at test start
   int cycles;

   logic [7:0] model [RAMDEPTH*NBYTES];    // Byte image of the array

   // Expected response of the one transaction in flight
   bit        pending;
   umi_cmd_t  exp_cmd;
   umi_addr_t exp_dst;
   umi_addr_t exp_src;
   mem_data_t exp_data;

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   umi_mem_agent u_dut (
      .clk          (clk),
      .rst          (rst),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready)
   );

   // ##########################################################
   // Compare tasks
   // ##########################################################

   task check_cmd(input string name, input umi_cmd_t got, input umi_cmd_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task check_addr(input string name, input umi_addr_t got, input umi_addr_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   task check_data(input string name, input mem_data_t got, input mem_data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h", name, got, exp);
      end
   endtask

   function automatic int total_errors();
      return errors + u_dut.u_assert.fail_count;   // Bound assertion failures count too
   endfunction

   task end_test(input string name);
      ntests++;
      if (total_errors() == test_err0) begin
         npass++;
         $display("test %-12s ok", name);
      end else begin
         $display("test %-12s %0d errors", name, total_errors() - test_err0);
      end
      test_err0 = total_errors();
   endtask

   // ##########################################################
   // Stimulus helpers
   // ##########################################################

   function automatic umi_cmd_t make_cmd(input logic [OPW-1:0] op,
                                         input logic [SIZEW-1:0] size,
                                         input logic [LENW-1:0] len);
      umi_cmd_t c;
      c = '0;
      c[CMD_OPCODE_LSB +: OPW] = op;
      c[CMD_SIZE_LSB +: SIZEW] = size;
      c[CMD_LEN_LSB +: LENW]   = len;
      return c;
   endfunction

   // Inputs change 10 ns after the edge, resp_ready drawn here too
   task next_cycle;
      @(posedge clk);
      #10;
      resp_ready = ({$random(seed)} % 100) < ready_pct;
   endtask

   // Transfer shape that stays inside one row
   task rand_shape(output logic [SIZEW-1:0] size, output logic [LENW-1:0] len, output int off);
      int nb;
      size = {$random(seed)} % 4;
      len  = {$random(seed)} % (NBYTES >> size);
      nb   = (int'(len) + 1) << size;
      off  = {$random(seed)} % (NBYTES - nb + 1);
   endtask

   task send_req(input logic [OPW-1:0] op, input umi_addr_t dst, input umi_addr_t src,
                 input mem_data_t data, input logic [SIZEW-1:0] size,
                 input logic [LENW-1:0] len);
      next_cycle();
      req_valid   = 1'b1;
      req_cmd     = make_cmd(op, size, len);
      req_dstaddr = dst;
      req_srcaddr = src;
      req_data    = data;
      @(negedge clk);
      while (!req_ready) begin            // Hold fields until accepted
         next_cycle();
         @(negedge clk);
      end
      next_cycle();                       // Handshake edge
      req_valid = 1'b0;
      req_cmd   = $random(seed);          // Garbage, DUT must have captured
      req_data  = {$random(seed), $random(seed)};
   endtask

   // Runs until the port is idle again, checks any response on the way
   task wait_done(input bit no_resp);
      @(negedge clk);
      while (!(req_ready && !pending)) begin
         if (resp_valid && resp_ready) begin
            if (no_resp || !pending) begin
               errors++;
               $display("Response seen while no request was waiting for one");
            end else begin
               check_cmd("resp_cmd", resp_cmd, exp_cmd);
               check_addr("resp_dstaddr", resp_dstaddr, exp_dst);
               check_addr("resp_srcaddr", resp_srcaddr, exp_src);
               check_data("resp_data", resp_data, exp_data);
               pending = 1'b0;
            end
         end
         next_cycle();
         @(negedge clk);
      end
   endtask

   task automatic do_write(input bit posted, output int row);
      logic [SIZEW-1:0] size;
      logic [LENW-1:0]  len;
      int               off;
      int               nb;
      umi_addr_t        dst;
      umi_addr_t        src;
      mem_data_t        data;
      rand_shape(size, len, off);
      nb   = (int'(len) + 1) << size;
      row  = {$random(seed)} % RAMDEPTH;
      dst  = $random(seed);                // Upper bits ride along unused
      dst[OFFW +: ROWW] = row[ROWW-1:0];
      dst[OFFW-1:0]     = off[OFFW-1:0];
      src  = $random(seed);
      data = {$random(seed), $random(seed)};
      for (int i = 0; i < nb; i++) begin
         model[row*NBYTES + off + i] = data[8*i +: 8];   // Low bytes land from offset up
      end
      if (!posted) begin
         exp_cmd  = make_cmd(OP_RESP_WR, size, len);
         exp_dst  = src;
         exp_src  = dst;
         exp_data = '0;
         pending  = 1'b1;
      end
      send_req(posted ? OP_REQ_WRPOSTED : OP_REQ_WR, dst, src, data, size, len);
      wait_done(posted);
   endtask

   task automatic do_read(input int row, input bit full);
      logic [SIZEW-1:0] size;
      logic [LENW-1:0]  len;
      int               off;
      int               nb;
      umi_addr_t        dst;
      umi_addr_t        src;
      if (full) begin
         size = 3'd3;                      // Whole row
         len  = 8'd0;
         off  = 0;
      end else begin
         rand_shape(size, len, off);
      end
      nb  = (int'(len) + 1) << size;
      dst = $random(seed);
      dst[OFFW +: ROWW] = row[ROWW-1:0];
      dst[OFFW-1:0]     = off[OFFW-1:0];
      src = $random(seed);
      exp_data = '0;                       // Bytes past the transfer read zero
      for (int i = 0; i < nb; i++) begin
         exp_data[8*i +: 8] = model[row*NBYTES + off + i];
      end
      exp_cmd = make_cmd(OP_RESP_RD, size, len);
      exp_dst = src;
      exp_src = dst;
      pending = 1'b1;
      send_req(OP_REQ_RD, dst, src, {$random(seed), $random(seed)}, size, len);
      wait_done(1'b0);
   endtask

   // ##########################################################
   // Run limit
   // ##########################################################

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ##########################################################
   // Test sequence
   // ##########################################################

   initial begin : main
      int             nlow;
      int             row;
      int             kind;
      logic [OPW-1:0] op;
      umi_addr_t      dst;
      seed        = 6;
      ready_pct   = 100;
      errors      = 0;
      checks      = 0;
      ntests      = 0;
      npass       = 0;
      test_err0   = 0;
      pending     = 1'b0;
      rst         = 1'b1;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b0;
      for (int i = 0; i < RAMDEPTH*NBYTES; i++) begin
         model[i] = 8'h00;
      end
      repeat (4) @(posedge clk);
      #10 rst = 1'b0;

      // Port stays closed while rows are zeroed
      nlow = 0;
      @(negedge clk);
      while (!req_ready) begin
         nlow++;
         @(negedge clk);
      end
      checks++;
      if (nlow != RAMDEPTH) begin
         errors++;
         $display("req_ready stayed low for %0d cycles after reset, not %0d", nlow, RAMDEPTH);
      end
      repeat (16) do_read({$random(seed)} % RAMDEPTH, 1'b1);
      end_test("clear_phase");

      ready_pct = 80;
      repeat (160) begin
         if ({$random(seed)} % 2 == 0) do_write(1'b0, row);
         else do_read({$random(seed)} % RAMDEPTH, 1'b0);
      end
      end_test("random_rw");

      repeat (40) do_write(1'b0, row);    // Ack fields checked in wait_done
      end_test("write_ack");

      repeat (40) begin
         do_write(1'b1, row);
         do_read(row, 1'b1);
      end
      end_test("posted");

      ready_pct = 20;                      // Heavy back-pressure
      repeat (60) begin
         kind = {$random(seed)} % 3;
         if (kind == 0) do_read({$random(seed)} % RAMDEPTH, 1'b0);
         else do_write(kind == 2, row);
      end
      end_test("backpressure");

      ready_pct = 80;
      repeat (20) begin
         do begin
            op = {$random(seed)} % 32;
         end while (op == OP_REQ_RD || op == OP_REQ_WR || op == OP_REQ_WRPOSTED);
         row = {$random(seed)} % RAMDEPTH;
         dst = '0;
         dst[OFFW +: ROWW] = row[ROWW-1:0];
         send_req(op, dst, $random(seed), {$random(seed), $random(seed)}, 3'd3, 8'd0);
         wait_done(1'b1);
         do_read(row, 1'b1);              // Row must be untouched
      end
      end_test("unsupported");

      $display("tests %0d, passed %0d, checks %0d, errors %0d",
               ntests, npass, checks, total_errors());
      if (total_errors() == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
